// ==== rtl/rsp_order_pkg.sv ====
/*
 * Shared widths, payload types and default sizes for the read response
 * reorder shim. Every RTL file and the testbench refer to these by scope.
 */

package rsp_order_pkg;

    // ========================================
    // Payload widths
    // ========================================

    // Client metadata travels with each request and is restored on the response
    localparam int MDATA_W = 16;

    // One response line as returned by the memory side
    localparam int DATA_W = 64;

    // ========================================
    // Payload types
    // ========================================

    // Metadata saved in a reorder slot at request time
    typedef logic [MDATA_W-1:0] t_mdata;

    // Data written into a reorder slot by a response
    typedef logic [DATA_W-1:0] t_data;

    // ========================================
    // Default sizing used by the top level
    // ========================================

    // Total reorder slots, which is also the tag space toward memory
    localparam int DEF_N_ENTRIES = 32;

    // Slots are interleaved over this many banks by the low tag bits
    localparam int DEF_N_BANKS = 4;

    // Free slots still left when the almost-full level rises, which covers
    // requests the client already has in flight when it sees the warning
    localparam int DEF_MIN_FREE_SLOTS = 2;

endpackage

// ==== rtl/rob_bank_if.sv ====
/*
 * Links one reorder bank to the dispatch and drain blocks. Dispatch writes
 * allocations and fills, drain polls the head slot and reads it out.
 */

`timescale 1ns/1ns

interface rob_bank_if
#(
    parameter int N_ENTRIES = 32,
    parameter int N_BANKS = 4
);
    // Slots held by each bank and the index width inside the bank
    localparam int SLOTS = N_ENTRIES / N_BANKS;
    localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    // Allocation writes the client metadata at request time
    logic                  alloc_en;
    logic [SLOT_W-1:0]     alloc_slot;
    rsp_order_pkg::t_mdata alloc_mdata;

    // Fill writes the response data and marks the slot ready
    logic                  fill_en;
    logic [SLOT_W-1:0]     fill_slot;
    rsp_order_pkg::t_data  fill_data;

    // Drain side read port, the flag is for rd_slot and is combinational
    logic                  rd_en;
    logic [SLOT_W-1:0]     rd_slot;
    logic                  filled;
    rsp_order_pkg::t_mdata rd_mdata;
    rsp_order_pkg::t_data  rd_data;

    modport dispatch (output alloc_en, alloc_slot, alloc_mdata, fill_en, fill_slot, fill_data);

    modport bank (input alloc_en, alloc_slot, alloc_mdata, fill_en, fill_slot, fill_data,
                  input rd_en, rd_slot, output filled, rd_mdata, rd_data);

    modport drain (output rd_en, rd_slot, input filled, rd_mdata, rd_data);

endinterface

// ==== rtl/rob_bank.sv ====
/*
 * One bank of reorder slots. Each slot keeps client metadata, response
 * data and a filled flag, and is read out through a registered port.
 */

`timescale 1ns/1ns

module rob_bank
#(
    parameter int SLOTS = 8
)
(
    input  logic  clk,
    input  logic  reset,

    rob_bank_if.bank  bif
);
    // Slot storage
    rsp_order_pkg::t_mdata mdata_mem [SLOTS];
    rsp_order_pkg::t_data  data_mem  [SLOTS];

    // One flag per slot, set by a fill and cleared when drain reads it
    logic [SLOTS-1:0] filled_q;

    // ========================================
    // Slot writes
    // ========================================

    // Metadata lands at the request edge and data at the response edge.
    // Both ports can write in the same cycle since they name different slots
    always_ff @(posedge clk)
    begin
        if (bif.alloc_en)
            mdata_mem[bif.alloc_slot] <= bif.alloc_mdata;
        if (bif.fill_en)
            data_mem[bif.fill_slot] <= bif.fill_data;
    end

    // A slot is read only after its fill, and is not filled again before
    // the tags wrap, so a clear and a set never meet on one slot
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            filled_q <= '0;
        end
        else
        begin
            if (bif.rd_en)
                filled_q[bif.rd_slot] <= 1'b0;
            if (bif.fill_en)
                filled_q[bif.fill_slot] <= 1'b1;
        end
    end

    // ========================================
    // Read port
    // ========================================

    // Drain polls the flag of the slot it is waiting on
    assign bif.filled = filled_q[bif.rd_slot];

    // Read data is registered and appears one cycle after rd_en
    always_ff @(posedge clk)
    begin
        if (bif.rd_en)
        begin
            bif.rd_mdata <= mdata_mem[bif.rd_slot];
            bif.rd_data <= data_mem[bif.rd_slot];
        end
    end

endmodule

// ==== rtl/rob_dispatch.sv ====
/*
 * Request side of the reorder shim. Hands out slots as memory tags, steers
 * returning tags into bank fills and tracks occupancy for almost-full.
 */

`timescale 1ns/1ns

module rob_dispatch
#(
    parameter int N_ENTRIES = 32,
    parameter int N_BANKS = 4,
    parameter int MIN_FREE_SLOTS = 2
)
(
    input  logic                          clk,
    input  logic                          reset,

    // Client requests
    input  logic                          req_valid,
    input  rsp_order_pkg::t_mdata         req_mdata,
    output logic                          req_almost_full,

    // Requests toward memory carry the slot index as the tag
    output logic                          fiu_req_valid,
    output logic [$clog2(N_ENTRIES)-1:0]  fiu_req_tag,

    // Out of order responses from memory
    input  logic                          fiu_rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0]  fiu_rsp_tag,
    input  rsp_order_pkg::t_data          fiu_rsp_data,

    // One pulse per slot released by the drain block
    input  logic                          deq,

    rob_bank_if.dispatch                  bifs [N_BANKS]
);
    localparam int TAG_W = $clog2(N_ENTRIES);
    localparam int BANK_W = $clog2(N_BANKS);
    localparam int CNT_W = $clog2(N_ENTRIES + 1);
    localparam int AF_LEVEL = N_ENTRIES - MIN_FREE_SLOTS - 1;

    logic [TAG_W-1:0] tail;
    logic [CNT_W-1:0] occupancy;

    // ========================================
    // Slot allocation
    // ========================================

    // The tail is the tag of the next request and wraps with the tag width
    always_ff @(posedge clk)
    begin
        if (reset)
            tail <= '0;
        else if (req_valid)
            tail <= tail + 1'b1;
    end

    // The tag goes out in the same cycle as the request
    assign fiu_req_valid = req_valid;
    assign fiu_req_tag = tail;

    // ========================================
    // Bank steering
    // ========================================

    // Low tag bits pick the bank and the upper bits pick the slot inside it,
    // for the allocating tail as well as for each returning tag
    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_bank
        assign bifs[b].alloc_en = req_valid && (tail[BANK_W-1:0] == BANK_W'(b));
        assign bifs[b].alloc_slot = tail[TAG_W-1:BANK_W];
        assign bifs[b].alloc_mdata = req_mdata;

        assign bifs[b].fill_en = fiu_rsp_valid && (fiu_rsp_tag[BANK_W-1:0] == BANK_W'(b));
        assign bifs[b].fill_slot = fiu_rsp_tag[TAG_W-1:BANK_W];
        assign bifs[b].fill_data = fiu_rsp_data;
    end

    // ========================================
    // Occupancy and almost-full
    // ========================================

    // A slot is held from its request until drain releases it
    always_ff @(posedge clk)
    begin
        if (reset)
            occupancy <= '0;
        else if (req_valid && !deq)
            occupancy <= occupancy + 1'b1;
        else if (!req_valid && deq)
            occupancy <= occupancy - 1'b1;
    end

    // Registered from the count, so the level trails the count by a cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            req_almost_full <= 1'b0;
        else
            req_almost_full <= (occupancy > CNT_W'(AF_LEVEL));
    end

endmodule

// ==== rtl/rob_drain.sv ====
/*
 * Response side of the reorder shim. Walks the slots in request order and
 * sends each one to the client as soon as its bank reports it filled.
 */

`timescale 1ns/1ns

module rob_drain
#(
    parameter int N_ENTRIES = 32,
    parameter int N_BANKS = 4
)
(
    input  logic                   clk,
    input  logic                   reset,

    // Releases one slot toward the occupancy count
    output logic                   deq,

    // Ordered responses to the client, with no back-pressure
    output logic                   afu_rsp_valid,
    output rsp_order_pkg::t_mdata  afu_rsp_mdata,
    output rsp_order_pkg::t_data   afu_rsp_data,

    rob_bank_if.drain              bifs [N_BANKS]
);
    localparam int TAG_W = $clog2(N_ENTRIES);
    localparam int BANK_W = $clog2(N_BANKS);

    // Oldest outstanding tag
    logic [TAG_W-1:0] head;
    logic [BANK_W-1:0] head_bank;

    // Bank read in the previous cycle, which owns the output registers
    logic [BANK_W-1:0] rd_bank_q;

    // Per-bank views gathered so they can be indexed at run time
    logic [N_BANKS-1:0]    bank_filled;
    rsp_order_pkg::t_mdata bank_mdata [N_BANKS];
    rsp_order_pkg::t_data  bank_data  [N_BANKS];

    assign head_bank = head[BANK_W-1:0];

    // ========================================
    // Head polling
    // ========================================

    // Every bank sees the head's slot index but only the owner is read
    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_bank
        assign bifs[b].rd_slot = head[TAG_W-1:BANK_W];
        assign bifs[b].rd_en = deq && (head_bank == BANK_W'(b));

        assign bank_filled[b] = bifs[b].filled;
        assign bank_mdata[b] = bifs[b].rd_mdata;
        assign bank_data[b] = bifs[b].rd_data;
    end

    // Read the head in the cycle its flag shows, one slot per cycle at most
    assign deq = bank_filled[head_bank];

    always_ff @(posedge clk)
    begin
        if (reset)
            head <= '0;
        else if (deq)
            head <= head + 1'b1;
    end

    // ========================================
    // Output stage
    // ========================================

    // Bank read data is registered, so valid and the bank select follow
    // rd_en by one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            afu_rsp_valid <= 1'b0;
            rd_bank_q <= '0;
        end
        else
        begin
            afu_rsp_valid <= deq;
            if (deq)
                rd_bank_q <= head_bank;
        end
    end

    assign afu_rsp_mdata = bank_mdata[rd_bank_q];
    assign afu_rsp_data = bank_data[rd_bank_q];

endmodule

// ==== rtl/rsp_order_top.sv ====
/*
 * Top level of the read response reorder shim. Wires the dispatch block,
 * the interleaved reorder banks and the drain block together.
 */

`timescale 1ns/1ns

module rsp_order_top
#(
    parameter int N_ENTRIES = rsp_order_pkg::DEF_N_ENTRIES,
    parameter int N_BANKS = rsp_order_pkg::DEF_N_BANKS,
    parameter int MIN_FREE_SLOTS = rsp_order_pkg::DEF_MIN_FREE_SLOTS
)
(
    input  logic                          clk,
    input  logic                          reset,

    // Client request side
    input  logic                          req_valid,
    input  rsp_order_pkg::t_mdata         req_mdata,
    output logic                          req_almost_full,

    // Tagged requests toward memory
    output logic                          fiu_req_valid,
    output logic [$clog2(N_ENTRIES)-1:0]  fiu_req_tag,

    // Out of order responses from memory
    input  logic                          fiu_rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0]  fiu_rsp_tag,
    input  rsp_order_pkg::t_data          fiu_rsp_data,

    // Responses to the client in request order
    output logic                          afu_rsp_valid,
    output rsp_order_pkg::t_mdata         afu_rsp_mdata,
    output rsp_order_pkg::t_data          afu_rsp_data
);
    // Slot release from drain back to the occupancy count
    logic deq;

    // One link per bank, shared by dispatch, the bank and drain
    rob_bank_if #(.N_ENTRIES(N_ENTRIES), .N_BANKS(N_BANKS)) bank_if [N_BANKS] ();

    // ========================================
    // Request and fill steering
    // ========================================

    rob_dispatch
    #(
        .N_ENTRIES(N_ENTRIES),
        .N_BANKS(N_BANKS),
        .MIN_FREE_SLOTS(MIN_FREE_SLOTS)
    )
    i_dispatch
    (
        .clk,
        .reset,
        .req_valid,
        .req_mdata,
        .req_almost_full,
        .fiu_req_valid,
        .fiu_req_tag,
        .fiu_rsp_valid,
        .fiu_rsp_tag,
        .fiu_rsp_data,
        .deq,
        .bifs(bank_if)
    );

    // ========================================
    // Reorder banks
    // ========================================

    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_bank
        rob_bank #(.SLOTS(N_ENTRIES / N_BANKS)) i_bank
        (
            .clk,
            .reset,
            .bif(bank_if[b])
        );
    end

    // ========================================
    // In-order drain
    // ========================================

    rob_drain #(.N_ENTRIES(N_ENTRIES), .N_BANKS(N_BANKS)) i_drain
    (
        .clk,
        .reset,
        .deq,
        .afu_rsp_valid,
        .afu_rsp_mdata,
        .afu_rsp_data,
        .bifs(bank_if)
    );

endmodule

// ==== verif/rsp_order_props.sv ====
/*
 * Protocol checks for the reorder shim, attached to its top level by bind.
 * They watch slot usage, slot release and the outputs during reset.
 */

`timescale 1ns/1ns

module rsp_order_props
#(
    parameter int N_ENTRIES = 32
)
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req_valid,
    input  logic  deq,
    input  logic  req_almost_full,
    input  logic  fiu_req_valid,
    input  logic  afu_rsp_valid
);
    // Slots in use, rebuilt from the request and release strobes
    int occupancy;

    always_ff @(posedge clk)
    begin
        if (reset)
            occupancy <= 0;
        else
            occupancy <= occupancy + (req_valid ? 1 : 0) - (deq ? 1 : 0);
    end

    // ========================================
    // Properties
    // ========================================

    // A request needs at least one free slot
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> (occupancy < N_ENTRIES))
        else $error("request issued with every reorder slot occupied");

    // Every client response comes from a held slot released in the cycle before
    a_rsp_after_deq: assert property (@(posedge clk) disable iff (reset)
        afu_rsp_valid |-> ($past(deq) && ($past(occupancy) != 0)))
        else $error("client response without a preceding release of a held slot");

    // Registered outputs clear one edge into reset, the tag strobe at once
    a_quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!afu_rsp_valid && !req_almost_full))
        else $error("registered output high during reset");

    a_no_req_in_reset: assert property (@(posedge clk)
        reset |-> !fiu_req_valid)
        else $error("memory request issued during reset");

endmodule

bind rsp_order_top rsp_order_props #(.N_ENTRIES(N_ENTRIES)) i_props
(
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .deq(deq),
    .req_almost_full(req_almost_full),
    .fiu_req_valid(fiu_req_valid),
    .afu_rsp_valid(afu_rsp_valid)
);

// ==== verif/tb_rsp_order.sv ====
/*
 * Table-driven testbench for the reorder shim. A memory model answers each
 * batch of tags in order, reversed or shuffled, and a checker compares the
 * client responses against an expected queue filled at request time.
 */

`timescale 1ns/1ns

module tb_rsp_order;

    localparam int N_ENTRIES = rsp_order_pkg::DEF_N_ENTRIES;
    localparam int N_BANKS = rsp_order_pkg::DEF_N_BANKS;
    localparam int MIN_FREE_SLOTS = rsp_order_pkg::DEF_MIN_FREE_SLOTS;
    localparam int TAG_W = $clog2(N_ENTRIES);
    // Largest batch without answers, which is also where almost-full rises
    localparam int BATCH = N_ENTRIES - MIN_FREE_SLOTS;
    localparam int TIMEOUT = 200;
    localparam int N_ROWS = 6;

    // Return orders used by the memory model
    localparam logic [1:0] ORD_IN = 2'd0;
    localparam logic [1:0] ORD_REV = 2'd1;
    localparam logic [1:0] ORD_RAND = 2'd2;

    typedef struct packed {
        logic [7:0]  count;
        logic [15:0] mdata_base;
        logic [31:0] seed;
        logic [1:0]  order;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    rsp_order_pkg::t_mdata req_mdata;
    logic                  req_almost_full;
    logic                  fiu_req_valid;
    logic [TAG_W-1:0]      fiu_req_tag;
    logic                  fiu_rsp_valid;
    logic [TAG_W-1:0]      fiu_rsp_tag;
    rsp_order_pkg::t_data  fiu_rsp_data;
    logic                  afu_rsp_valid;
    rsp_order_pkg::t_mdata afu_rsp_mdata;
    rsp_order_pkg::t_data  afu_rsp_data;

    row_t rows [N_ROWS];

    // Expected responses in request order, and the tags the model still owes
    rsp_order_pkg::t_mdata exp_mdata_q [$];
    rsp_order_pkg::t_data  exp_data_q [$];
    logic [TAG_W-1:0]      issued [$];

    // Fill cycles of in-order rows, used for the fixed latency check
    int fill_cycle_q [$];
    int cycle = 0;
    int req_count;
    bit check_latency;
    integer seed;

    rsp_order_top
    #(
        .N_ENTRIES(N_ENTRIES),
        .N_BANKS(N_BANKS),
        .MIN_FREE_SLOTS(MIN_FREE_SLOTS)
    )
    i_dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // ========================================
    // Helpers
    // ========================================

    // Response line for a tag: seed in the upper word and a tag mix below
    function automatic rsp_order_pkg::t_data line_for(logic [31:0] seed_val,
                                                      logic [TAG_W-1:0] tag);
        return {seed_val, seed_val ^ {tag, 3'b000, tag, 3'b000, tag, 3'b000, tag, 3'b000}};
    endfunction

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        $display("tests failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_problem(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "%s", what);
    endtask

    // ========================================
    // Response checker
    // ========================================

    // Sampled on the falling edge where every output has settled
    always @(negedge clk)
    begin
        if (!reset && fiu_rsp_valid && check_latency)
            fill_cycle_q.push_back(cycle);
        if (!reset && afu_rsp_valid)
        begin
            if (exp_mdata_q.size() == 0)
                report_problem("client response arrived with nothing outstanding");
            else
            begin
                assert (afu_rsp_mdata == exp_mdata_q[0])
                    else report_mismatch("afu_rsp_mdata", 64'(afu_rsp_mdata),
                                         64'(exp_mdata_q[0]));
                assert (afu_rsp_data == exp_data_q[0])
                    else report_mismatch("afu_rsp_data", afu_rsp_data, exp_data_q[0]);
                void'(exp_mdata_q.pop_front());
                void'(exp_data_q.pop_front());
                // In-order answers hit the head slot, so fill to output is two cycles
                if (check_latency)
                begin
                    assert (cycle - fill_cycle_q[0] == 2)
                        else report_mismatch("afu_rsp_valid latency",
                                             64'(cycle - fill_cycle_q[0]), 64'd2);
                    void'(fill_cycle_q.pop_front());
                end
            end
        end
    end

    // ========================================
    // Client and memory models
    // ========================================

    // Issue one request after the edge and check the tag it goes out with
    task automatic send_request(rsp_order_pkg::t_mdata mdata, logic [31:0] seed_val);
        logic [TAG_W-1:0] exp_tag;
        exp_tag = TAG_W'(req_count);
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req_mdata = mdata;
        @(negedge clk);
        assert (fiu_req_valid)
            else report_problem("fiu_req_valid did not follow req_valid");
        assert (fiu_req_tag == exp_tag)
            else report_mismatch("fiu_req_tag", 64'(fiu_req_tag), 64'(exp_tag));
        assert (!req_almost_full)
            else report_problem("req_almost_full rose before the reserve was reached");
        exp_mdata_q.push_back(mdata);
        exp_data_q.push_back(line_for(seed_val, exp_tag));
        issued.push_back(exp_tag);
        req_count++;
    endtask

    // Answer every collected tag once, in the order the row asks for
    task automatic answer_batch(logic [1:0] order, logic [31:0] seed_val);
        logic [TAG_W-1:0] tags [$];
        logic [TAG_W-1:0] tmp;
        int j;
        foreach (issued[i])
        begin
            if (order == ORD_REV)
                tags.push_front(issued[i]);
            else
                tags.push_back(issued[i]);
        end
        issued.delete();
        // Fisher-Yates shuffle drawn from the fixed seed
        if (order == ORD_RAND)
        begin
            for (int i = tags.size() - 1; i > 0; i--)
            begin
                j = int'($unsigned($random(seed)) % (i + 1));
                tmp = tags[i];
                tags[i] = tags[j];
                tags[j] = tmp;
            end
        end
        foreach (tags[k])
        begin
            @(posedge clk);
            #2;
            fiu_rsp_valid = 1'b1;
            fiu_rsp_tag = tags[k];
            fiu_rsp_data = line_for(seed_val, tags[k]);
        end
        @(posedge clk);
        #2;
        fiu_rsp_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_mdata_q.size() != 0)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_problem("timed out waiting for the client responses to drain");
        end
    endtask

    // A row larger than the reserve is split into batches that each drain
    task automatic run_row(row_t row);
        int sent;
        int n;
        sent = 0;
        while (sent < int'(row.count))
        begin
            n = ((int'(row.count) - sent) > BATCH) ? BATCH : (int'(row.count) - sent);
            for (int i = 0; i < n; i++)
                send_request(row.mdata_base + rsp_order_pkg::t_mdata'(sent + i), row.seed);
            @(posedge clk);
            #2;
            req_valid = 1'b0;
            // Count settles one edge after the last request, the level one more
            if (n == BATCH)
            begin
                repeat (2) @(negedge clk);
                assert (req_almost_full)
                    else report_problem("req_almost_full stayed low with the reserve reached");
            end
            check_latency = (row.order == ORD_IN);
            answer_batch(row.order, row.seed);
            wait_drained();
            check_latency = 1'b0;
            @(negedge clk);
            assert (!req_almost_full)
                else report_problem("req_almost_full still high after the batch drained");
            sent += n;
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        seed = 32'h932ed819;
        req_count = 0;
        check_latency = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_mdata = '0;
        fiu_rsp_valid = 1'b0;
        fiu_rsp_tag = '0;
        fiu_rsp_data = '0;

        // Count, metadata base, data seed, return order
        rows[0] = '{8'd8, 16'h1000, 32'h0badcafe, ORD_IN};
        rows[1] = '{8'd12, 16'h2000, 32'h13579bdf, ORD_REV};
        rows[2] = '{8'd30, 16'h3000, 32'h2468ace0, ORD_RAND};
        rows[3] = '{8'd40, 16'h4000, 32'hfeedf00d, ORD_RAND};
        rows[4] = '{8'd30, 16'h5000, 32'h5a5aa5a5, ORD_IN};
        rows[5] = '{8'd5, 16'h6000, 32'h71c3e00f, ORD_REV};

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!req_almost_full && !fiu_req_valid && !afu_rsp_valid)
            else report_problem("an output was high right after reset");

        foreach (rows[r])
            run_row(rows[r]);

        // Idle time lets any stray response show up in the checker
        repeat (10) @(negedge clk);
        if (exp_mdata_q.size() == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            report_problem("responses still outstanding at the end of the run");
    end

endmodule

// ==== list.f ====
rtl/rsp_order_pkg.sv
rtl/rob_bank_if.sv
rtl/rob_bank.sv
rtl/rob_dispatch.sv
rtl/rob_drain.sv
rtl/rsp_order_top.sv
verif/rsp_order_props.sv
verif/tb_rsp_order.sv

// ==== Makefile ====
# Verilator lint, build and simulation for the read response reorder shim
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rsp_order
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, so a run that stops early counts as a failure
sim: build
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
